// File: common/aes_ctrl_pkg.sv
package aes_ctrl_pkg;

	// =========================================================================
	// Widths
	// =========================================================================

	localparam int blk_w = 128;
	localparam int key_w = 2 * blk_w;

	// One cipher block
	typedef logic [blk_w-1:0] blk_t;

	// Full key, first key word in the upper half
	typedef logic [key_w-1:0] key_t;

	// =========================================================================
	// Command word layout
	// =========================================================================

	// Only ECB and CBC are handled, any other code drains the job
	typedef enum logic [2:0] {
		mode_ecb = 3'd0,
		mode_cbc = 3'd1
	} mode_t;

	// Low five bits of the command word
	typedef struct packed {
		mode_t mode;
		logic  key256;
		logic  encrypt;
	} cmd_t;

	// Block plus last flag, same on input, between stages and on output
	typedef struct packed {
		logic last;
		blk_t blk;
	} word_t;

	// Request sent to the external cipher engine
	typedef struct packed {
		blk_t blk;
		key_t key;
		logic key256;
		logic decipher;
	} eng_req_t;

	// Loader states
	typedef enum logic [2:0] {
		get_cmd    = 3'b000,
		get_key_hi = 3'b001,
		get_key_lo = 3'b010,
		payload    = 3'b100
	} loader_state_t;

	// Held stable for the length of one payload
	typedef struct packed {
		logic  encrypt;
		logic  key256;
		mode_t mode;
		key_t  key;
	} job_t;

endpackage

// File: hw/word_rx.sv
`timescale 1ns/100ps

module word_rx (
	input  logic                aes_clk,
	input  logic                aes_reset,
	input  logic                in_req,
	input  aes_ctrl_pkg::word_t in_word,
	output logic                in_ack,
	output aes_ctrl_pkg::word_t rx_word,
	output logic                rx_valid,
	input  logic                rx_ready
);

	typedef enum logic {
		rx_idle,
		rx_ack
	} rx_state_t;

	rx_state_t state;
	logic      capture;

	// New word only with the stage empty and the previous handshake closed
	assign capture = (state == rx_idle) && in_req && !rx_valid;
	assign in_ack = (state == rx_ack);

	always_ff @(posedge aes_clk) begin
		if (aes_reset) begin
			state <= rx_idle;
			rx_valid <= 1'b0;
		end else begin
			if (rx_valid && rx_ready)
				rx_valid <= 1'b0;
			case (state)
				rx_idle: begin
					if (capture) begin
						state <= rx_ack;
						rx_valid <= 1'b1;
					end
				end
				rx_ack: begin
					// Hold ack until the sender lets go of req
					if (!in_req)
						state <= rx_idle;
				end
				default: state <= rx_idle;
			endcase
		end
	end

	always_ff @(posedge aes_clk) begin
		if (capture)
			rx_word <= in_word;
	end

	// Sender keeps the word still until we acknowledge it
	a_in_word_stable: assert property (@(posedge aes_clk) disable iff (aes_reset)
		in_req && !in_ack |=> !(in_req && !in_ack) || $stable(in_word));

endmodule

// File: hw/cmd_key_loader.sv
`timescale 1ns/100ps

module cmd_key_loader (
	input  logic                aes_clk,
	input  logic                aes_reset,
	input  aes_ctrl_pkg::word_t rx_word,
	input  logic                rx_valid,
	output logic                rx_ready,
	output aes_ctrl_pkg::job_t  job,
	output aes_ctrl_pkg::word_t pl_word,
	output logic                pl_valid,
	input  logic                pl_ready,
	input  logic                job_done
);

	localparam int blk_w = aes_ctrl_pkg::blk_w;

	aes_ctrl_pkg::loader_state_t state;
	aes_ctrl_pkg::cmd_t          cmd;
	logic                        last_sent;
	logic                        rx_fire;
	logic                        pl_fire;

	assign cmd = aes_ctrl_pkg::cmd_t'(rx_word.blk[$bits(aes_ctrl_pkg::cmd_t)-1:0]);
	assign rx_fire = rx_valid && rx_ready;
	assign pl_fire = pl_valid && pl_ready;

	// Payload goes straight through, the chaining unit holds the item
	assign pl_word = rx_word;

	// =========================================================================
	// Flow control
	// =========================================================================

	always_comb begin
		rx_ready = 1'b0;
		pl_valid = 1'b0;
		case (state)
			aes_ctrl_pkg::get_cmd,
			aes_ctrl_pkg::get_key_hi,
			aes_ctrl_pkg::get_key_lo: begin
				rx_ready = 1'b1;
			end
			aes_ctrl_pkg::payload: begin
				// Nothing past the last block until the job is closed
				pl_valid = rx_valid && !last_sent;
				rx_ready = pl_ready && !last_sent;
			end
			default: begin
				rx_ready = 1'b0;
			end
		endcase
	end

	// =========================================================================
	// State machine
	// =========================================================================

	always_ff @(posedge aes_clk) begin
		if (aes_reset) begin
			state <= aes_ctrl_pkg::get_cmd;
			last_sent <= 1'b0;
		end else begin
			case (state)
				aes_ctrl_pkg::get_cmd: begin
					if (rx_fire)
						state <= aes_ctrl_pkg::get_key_hi;
				end
				aes_ctrl_pkg::get_key_hi: begin
					if (rx_fire)
						state <= job.key256 ? aes_ctrl_pkg::get_key_lo : aes_ctrl_pkg::payload;
				end
				aes_ctrl_pkg::get_key_lo: begin
					if (rx_fire)
						state <= aes_ctrl_pkg::payload;
				end
				aes_ctrl_pkg::payload: begin
					if (pl_fire && pl_word.last)
						last_sent <= 1'b1;
					if (job_done) begin
						state <= aes_ctrl_pkg::get_cmd;
						last_sent <= 1'b0;
					end
				end
				default: state <= aes_ctrl_pkg::get_cmd;
			endcase
		end
	end

	// Job fields, loaded from the command and key words
	always_ff @(posedge aes_clk) begin
		if (rx_fire && state == aes_ctrl_pkg::get_cmd) begin
			job.encrypt <= cmd.encrypt;
			job.key256 <= cmd.key256;
			job.mode <= cmd.mode;
		end
		if (rx_fire && state == aes_ctrl_pkg::get_key_hi)
			job.key[2*blk_w-1:blk_w] <= rx_word.blk;
		if (rx_fire && state == aes_ctrl_pkg::get_key_lo)
			job.key[blk_w-1:0] <= rx_word.blk;
	end

	a_state_legal: assert property (@(posedge aes_clk) disable iff (aes_reset)
		state inside {aes_ctrl_pkg::get_cmd, aes_ctrl_pkg::get_key_hi,
			aes_ctrl_pkg::get_key_lo, aes_ctrl_pkg::payload});

endmodule

// File: chain_mode/chain_mode_unit.sv
`timescale 1ns/100ps

module chain_mode_unit #(
	parameter bit cbc_support = 1'b1
) (
	input  logic                   aes_clk,
	input  logic                   aes_reset,
	input  aes_ctrl_pkg::job_t     job,
	input  aes_ctrl_pkg::word_t    pl_word,
	input  logic                   pl_valid,
	output logic                   pl_ready,
	output logic                   job_done,
	output logic                   eng_req,
	output aes_ctrl_pkg::eng_req_t eng_data,
	input  logic                   eng_ack,
	input  aes_ctrl_pkg::blk_t     eng_blk,
	output aes_ctrl_pkg::word_t    tx_word,
	output logic                   tx_valid,
	input  logic                   tx_ready
);

	typedef enum logic {
		cm_idle,
		cm_eng
	} cm_state_t;

	cm_state_t          state;
	logic               first_blk;
	logic               use_cbc;
	logic               mode_ok;
	logic               to_engine;
	logic               pl_fire;
	logic               eng_done;
	aes_ctrl_pkg::blk_t chain;
	aes_ctrl_pkg::blk_t result;

	// =========================================================================
	// Mode decode
	// =========================================================================

	assign use_cbc = cbc_support && (job.mode == aes_ctrl_pkg::mode_cbc);
	assign mode_ok = (job.mode == aes_ctrl_pkg::mode_ecb) || use_cbc;

	// IV block and unsupported modes never reach the engine
	assign to_engine = mode_ok && !(use_cbc && first_blk);

	// One item at a time, and the engine must have closed its handshake
	assign pl_ready = (state == cm_idle) && !tx_valid && !eng_ack;
	assign pl_fire = pl_valid && pl_ready;
	assign eng_req = (state == cm_eng);
	assign eng_done = eng_req && eng_ack;

	always_comb begin
		result = eng_blk;
		if (use_cbc && !job.encrypt)
			result = eng_blk ^ chain;
	end

	// =========================================================================
	// Control
	// =========================================================================

	always_ff @(posedge aes_clk) begin
		if (aes_reset) begin
			state <= cm_idle;
			tx_valid <= 1'b0;
			job_done <= 1'b0;
			first_blk <= 1'b1;
		end else begin
			job_done <= 1'b0;
			if (tx_valid && tx_ready) begin
				tx_valid <= 1'b0;
				job_done <= tx_word.last;
			end
			if (pl_fire) begin
				first_blk <= 1'b0;
				if (to_engine)
					state <= cm_eng;
				else
					job_done <= pl_word.last;
			end
			if (eng_done) begin
				state <= cm_idle;
				tx_valid <= 1'b1;
			end
			// Next job starts again with its IV
			if (job_done)
				first_blk <= 1'b1;
		end
	end

	// =========================================================================
	// Data path
	// =========================================================================

	always_ff @(posedge aes_clk) begin
		if (pl_fire && use_cbc && first_blk)
			chain <= pl_word.blk;
		if (pl_fire && to_engine) begin
			// CBC encryption folds the chain in before the engine
			eng_data.blk <= (use_cbc && job.encrypt) ? pl_word.blk ^ chain : pl_word.blk;
			eng_data.key <= job.key;
			eng_data.key256 <= job.key256;
			eng_data.decipher <= !job.encrypt;
			tx_word.last <= pl_word.last;
		end
		if (eng_done) begin
			tx_word.blk <= result;
			// New chain is always the ciphertext
			if (use_cbc)
				chain <= job.encrypt ? eng_blk : eng_data.blk;
		end
	end

	a_eng_data_stable: assert property (@(posedge aes_clk) disable iff (aes_reset)
		eng_req |=> !eng_req || $stable(eng_data));

	a_eng_req_rise: assert property (@(posedge aes_clk) disable iff (aes_reset)
		$rose(eng_req) |-> !eng_ack);

endmodule

// File: hw/word_tx.sv
`timescale 1ns/100ps

module word_tx (
	input  logic                aes_clk,
	input  logic                aes_reset,
	input  aes_ctrl_pkg::word_t tx_word,
	input  logic                tx_valid,
	output logic                tx_ready,
	output logic                out_req,
	output aes_ctrl_pkg::word_t out_word,
	input  logic                out_ack
);

	typedef enum logic [1:0] {
		tx_idle,
		tx_req,
		tx_drop
	} tx_state_t;

	tx_state_t state;

	assign tx_ready = (state == tx_idle);
	assign out_req = (state == tx_req);

	always_ff @(posedge aes_clk) begin
		if (aes_reset) begin
			state <= tx_idle;
		end else begin
			case (state)
				tx_idle: if (tx_valid) state <= tx_req;
				tx_req: if (out_ack) state <= tx_drop;
				// Wait for the receiver to close the handshake
				tx_drop: if (!out_ack) state <= tx_idle;
				default: state <= tx_idle;
			endcase
		end
	end

	// Output hold register
	always_ff @(posedge aes_clk) begin
		if (tx_valid && tx_ready)
			out_word <= tx_word;
	end

	a_req_held: assert property (@(posedge aes_clk) disable iff (aes_reset)
		$fell(out_req) |-> $past(out_ack));

endmodule

// File: hw/aes_ctrl_top.sv
`timescale 1ns/100ps

module aes_ctrl_top #(
	parameter bit cbc_support = 1'b1
) (
	input  logic                   aes_clk,
	input  logic                   aes_reset,

	// Input words, four-phase
	input  logic                   in_req,
	input  aes_ctrl_pkg::word_t    in_word,
	output logic                   in_ack,

	// Result words, four-phase
	output logic                   out_req,
	output aes_ctrl_pkg::word_t    out_word,
	input  logic                   out_ack,

	// External cipher engine
	output logic                   eng_req,
	output aes_ctrl_pkg::eng_req_t eng_data,
	input  logic                   eng_ack,
	input  aes_ctrl_pkg::blk_t     eng_blk
);

	aes_ctrl_pkg::word_t rx_word;
	logic                rx_valid;
	logic                rx_ready;

	aes_ctrl_pkg::word_t pl_word;
	logic                pl_valid;
	logic                pl_ready;
	aes_ctrl_pkg::job_t  job;
	logic                job_done;

	aes_ctrl_pkg::word_t tx_word;
	logic                tx_valid;
	logic                tx_ready;

	// =========================================================================
	// Stages
	// =========================================================================

	word_rx word_rx_i (
		.aes_clk   (aes_clk),
		.aes_reset (aes_reset),
		.in_req    (in_req),
		.in_word   (in_word),
		.in_ack    (in_ack),
		.rx_word   (rx_word),
		.rx_valid  (rx_valid),
		.rx_ready  (rx_ready)
	);

	cmd_key_loader cmd_key_loader_i (
		.aes_clk   (aes_clk),
		.aes_reset (aes_reset),
		.rx_word   (rx_word),
		.rx_valid  (rx_valid),
		.rx_ready  (rx_ready),
		.job       (job),
		.pl_word   (pl_word),
		.pl_valid  (pl_valid),
		.pl_ready  (pl_ready),
		.job_done  (job_done)
	);

	chain_mode_unit #(
		.cbc_support (cbc_support)
	) chain_mode_unit_i (
		.aes_clk   (aes_clk),
		.aes_reset (aes_reset),
		.job       (job),
		.pl_word   (pl_word),
		.pl_valid  (pl_valid),
		.pl_ready  (pl_ready),
		.job_done  (job_done),
		.eng_req   (eng_req),
		.eng_data  (eng_data),
		.eng_ack   (eng_ack),
		.eng_blk   (eng_blk),
		.tx_word   (tx_word),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready)
	);

	word_tx word_tx_i (
		.aes_clk   (aes_clk),
		.aes_reset (aes_reset),
		.tx_word   (tx_word),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready),
		.out_req   (out_req),
		.out_word  (out_word),
		.out_ack   (out_ack)
	);

endmodule

// File: dv/tb_cipher_engine.sv
`timescale 1ns/100ps

module tb_cipher_engine (
	input  logic                   aes_clk,
	input  logic                   aes_reset,
	input  logic                   eng_req,
	input  aes_ctrl_pkg::eng_req_t eng_data,
	output logic                   eng_ack,
	output aes_ctrl_pkg::blk_t     eng_blk
);

	typedef enum logic [1:0] {
		eng_idle,
		eng_busy,
		eng_hold,
		eng_release
	} eng_state_t;

	eng_state_t  state = eng_idle;
	int unsigned delay = 0;

	// Toy cipher, XOR with the effective key and a one bit rotation
	function automatic aes_ctrl_pkg::blk_t engine_result(input aes_ctrl_pkg::eng_req_t d);
		aes_ctrl_pkg::blk_t k;
		aes_ctrl_pkg::blk_t x;
		k = d.key256 ? d.key[255:128] ^ d.key[127:0] : d.key[255:128];
		if (d.decipher) begin
			x = {d.blk[0], d.blk[127:1]};
			return x ^ k;
		end
		x = d.blk ^ k;
		return {x[126:0], x[127]};
	endfunction

	initial begin
		eng_ack = 1'b0;
		eng_blk = '0;
	end

	always @(posedge aes_clk) begin
		#0.5;
		if (aes_reset) begin
			state = eng_idle;
			eng_ack = 1'b0;
		end else begin
			case (state)
				eng_idle: begin
					if (eng_req) begin
						delay = $urandom_range(3, 0);
						state = eng_busy;
					end
				end
				eng_busy: begin
					if (delay == 0) begin
						eng_blk = engine_result(eng_data);
						eng_ack = 1'b1;
						state = eng_hold;
					end else begin
						delay--;
					end
				end
				eng_hold: begin
					// Result stays valid until the request is withdrawn
					if (!eng_req) begin
						delay = $urandom_range(2, 0);
						state = eng_release;
					end
				end
				eng_release: begin
					if (delay == 0) begin
						eng_ack = 1'b0;
						state = eng_idle;
					end else begin
						delay--;
					end
				end
			endcase
		end
	end

endmodule

// File: dv/aes_ctrl_tb.sv
`timescale 1ns/100ps

module aes_ctrl_tb;

	localparam int unsigned seed = 32'h591f1902;
	localparam realtime half_period = 2.0;
	localparam int hs_timeout = 400;
	localparam int drain_timeout = 2000;
	localparam int stall_limit = 40;

	logic                   aes_clk = 1'b0;
	logic                   aes_reset;
	logic                   in_req;
	aes_ctrl_pkg::word_t    in_word;
	logic                   in_ack;
	logic                   out_req;
	aes_ctrl_pkg::word_t    out_word;
	logic                   out_ack = 1'b0;
	logic                   eng_req;
	aes_ctrl_pkg::eng_req_t eng_data;
	logic                   eng_ack;
	aes_ctrl_pkg::blk_t     eng_blk;

	// Expected output FIFO
	aes_ctrl_pkg::word_t exp_mem [0:255];
	aes_ctrl_pkg::word_t exp_word;
	logic [7:0]          exp_wr = '0;
	logic [7:0]          exp_rd = '0;

	int          errors = 0;
	int          checked = 0;
	int          stall_cnt = 0;
	int unsigned ack_wait = 0;
	logic        ack_armed = 1'b0;
	logic        stall_used = 1'b0;
	logic        long_stall = 1'b0;
	logic        bp_mode = 1'b0;
	logic        drain_job = 1'b0;
	logic        seen_req = 1'b0;
	logic        timed_out = 1'b0;

	aes_ctrl_pkg::blk_t key_hi;
	aes_ctrl_pkg::blk_t key_lo;
	aes_ctrl_pkg::blk_t iv;
	aes_ctrl_pkg::blk_t src [0:15];
	aes_ctrl_pkg::blk_t res [0:15];

	assign exp_word = exp_mem[exp_rd];

	always #(half_period) aes_clk = ~aes_clk;

	aes_ctrl_top #(
		.cbc_support (1'b1)
	) dut_i (
		.aes_clk   (aes_clk),
		.aes_reset (aes_reset),
		.in_req    (in_req),
		.in_word   (in_word),
		.in_ack    (in_ack),
		.out_req   (out_req),
		.out_word  (out_word),
		.out_ack   (out_ack),
		.eng_req   (eng_req),
		.eng_data  (eng_data),
		.eng_ack   (eng_ack),
		.eng_blk   (eng_blk)
	);

	tb_cipher_engine engine_i (
		.aes_clk   (aes_clk),
		.aes_reset (aes_reset),
		.eng_req   (eng_req),
		.eng_data  (eng_data),
		.eng_ack   (eng_ack),
		.eng_blk   (eng_blk)
	);

	// ========================================================================
	// Reference model of the engine and the chaining rules
	// ========================================================================

	function automatic aes_ctrl_pkg::blk_t eff_key(input logic k256);
		return k256 ? key_hi ^ key_lo : key_hi;
	endfunction

	function automatic aes_ctrl_pkg::blk_t encipher(input aes_ctrl_pkg::blk_t b,
		input logic k256);
		aes_ctrl_pkg::blk_t x;
		x = b ^ eff_key(k256);
		return {x[126:0], x[127]};
	endfunction

	function automatic aes_ctrl_pkg::blk_t decipher(input aes_ctrl_pkg::blk_t b,
		input logic k256);
		return {b[0], b[127:1]} ^ eff_key(k256);
	endfunction

	function automatic aes_ctrl_pkg::blk_t rand_blk();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// ========================================================================
	// Output side ack driver and bookkeeping
	// ========================================================================

	always @(posedge aes_clk) begin
		#0.5;
		if (out_ack) begin
			if (!out_req)
				out_ack = 1'b0;
		end else if (out_req) begin
			if (!ack_armed) begin
				ack_armed = 1'b1;
				if (long_stall && !stall_used) begin
					stall_used = 1'b1;
					ack_wait = 100;
				end else begin
					ack_wait = bp_mode ? $urandom_range(12, 0) : $urandom_range(2, 0);
				end
			end
			if (ack_wait == 0) begin
				out_ack = 1'b1;
				ack_armed = 1'b0;
			end else begin
				ack_wait--;
			end
		end
	end

	always @(posedge aes_clk) begin
		if (in_req)
			seen_req <= 1'b1;
		stall_cnt <= (out_req && !out_ack) ? stall_cnt + 1 : 0;
		if (out_req && out_ack) begin
			exp_rd <= exp_rd + 1'b1;
			checked <= checked + 1;
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	a_out_match: assert property (@(posedge aes_clk) disable iff (aes_reset)
		out_req && out_ack && exp_rd != exp_wr |-> out_word == exp_word)
	else begin
		errors++;
		$display("** Error at %0t ns: out_word got %h expected %h",
			$time, $sampled(out_word), $sampled(exp_word));
	end

	a_out_expected: assert property (@(posedge aes_clk) disable iff (aes_reset)
		out_req && out_ack |-> exp_rd != exp_wr)
	else begin
		errors++;
		$display("Error at %0t ns: output word arrived with none expected", $time);
	end

	a_drain_no_eng: assert property (@(posedge aes_clk) disable iff (aes_reset)
		drain_job |-> !eng_req)
	else begin
		errors++;
		$display("Error at %0t ns: engine request during an unsupported mode job", $time);
	end

	a_reset_quiet: assert property (@(posedge aes_clk) disable iff (aes_reset)
		!seen_req |-> !out_req && !in_ack && !eng_req)
	else begin
		errors++;
		$display("Error at %0t ns: handshake output high before the first input", $time);
	end

	a_in_stall: assert property (@(posedge aes_clk) disable iff (aes_reset)
		stall_cnt > stall_limit |-> !$rose(in_ack))
	else begin
		errors++;
		$display("Error at %0t ns: input accepted while the output was stalled", $time);
	end

	// ========================================================================
	// Stimulus tasks
	// ========================================================================

	task automatic finish_run();
		$display("Checked %0d output words, %0d left over, %0d errors, timeout %0b",
			checked, exp_wr - exp_rd, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic wait_in_ack(input logic level);
		int cnt;
		cnt = 0;
		if (timed_out)
			return;
		do begin
			@(posedge aes_clk);
			#0.5;
			cnt++;
		end while (in_ack !== level && cnt < hs_timeout);
		if (in_ack !== level) begin
			timed_out = 1'b1;
			$display("Timeout at %0t ns: in_ack never went to %0b", $time, level);
		end
	endtask

	task automatic wait_drained();
		int cnt;
		cnt = 0;
		while (!timed_out && exp_rd != exp_wr && cnt < drain_timeout) begin
			@(posedge aes_clk);
			#0.5;
			cnt++;
		end
		if (!timed_out && exp_rd != exp_wr) begin
			timed_out = 1'b1;
			$display("Timeout at %0t ns: expected output words never arrived", $time);
		end
	endtask

	task automatic send_word(input aes_ctrl_pkg::blk_t b, input logic last);
		if (timed_out)
			return;
		in_word = {last, b};
		in_req = 1'b1;
		wait_in_ack(1'b1);
		in_req = 1'b0;
		wait_in_ack(1'b0);
	endtask

	task automatic push_exp(input aes_ctrl_pkg::blk_t b, input logic last);
		exp_mem[exp_wr] = {last, b};
		exp_wr = exp_wr + 1'b1;
	endtask

	task automatic new_data();
		key_hi = rand_blk();
		key_lo = rand_blk();
		iv = rand_blk();
		for (int i = 0; i < 16; i++)
			src[i] = rand_blk();
	endtask

	// One job of n payload blocks from src with results in res
	task automatic run_job(input logic enc, input logic k256, input logic [2:0] mode,
		input int n);
		aes_ctrl_pkg::blk_t cmd;
		aes_ctrl_pkg::blk_t chain;
		aes_ctrl_pkg::blk_t r;
		logic               cbc;
		logic               known;
		cmd = '0;
		cmd[0] = enc;
		cmd[1] = k256;
		cmd[4:2] = mode;
		cbc = (mode == 3'd1);
		known = (mode == 3'd0) || cbc;
		chain = iv;
		// Expected words are queued before any input is sent
		for (int i = 0; i < n; i++) begin
			if (!cbc) begin
				r = enc ? encipher(src[i], k256) : decipher(src[i], k256);
			end else if (enc) begin
				r = encipher(src[i] ^ chain, k256);
				chain = r;
			end else begin
				r = decipher(src[i], k256) ^ chain;
				chain = src[i];
			end
			res[i] = r;
			if (known)
				push_exp(r, i == n - 1);
		end
		send_word(cmd, 1'b0);
		send_word(key_hi, 1'b0);
		if (k256)
			send_word(key_lo, 1'b0);
		if (cbc)
			send_word(iv, 1'b0);
		for (int i = 0; i < n; i++)
			send_word(src[i], i == n - 1);
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		void'($urandom(seed));
		aes_reset = 1'b1;
		in_req = 1'b0;
		in_word = '0;
		repeat (2) @(posedge aes_clk);
		#0.5;
		aes_reset = 1'b0;
		// Idle cycles for the reset state check
		repeat (4) @(posedge aes_clk);
		#0.5;

		// ECB with a 128-bit key in both directions
		new_data();
		run_job(1'b1, 1'b0, 3'd0, 4);
		run_job(1'b0, 1'b0, 3'd0, 4);
		wait_drained();

		// CBC encryption with a 256-bit key and decryption of that ciphertext
		new_data();
		run_job(1'b1, 1'b1, 3'd1, 5);
		for (int i = 0; i < 5; i++)
			src[i] = res[i];
		run_job(1'b0, 1'b1, 3'd1, 5);
		wait_drained();

		// Unsupported mode drains silently before a normal job
		new_data();
		drain_job = 1'b1;
		run_job(1'b1, 1'b0, 3'd5, 3);
		drain_job = 1'b0;
		run_job(1'b1, 1'b1, 3'd0, 3);
		wait_drained();

		// Back-pressure with one long stall at the start
		bp_mode = 1'b1;
		long_stall = 1'b1;
		new_data();
		run_job(1'b1, 1'b0, 3'd0, 10);
		run_job(1'b1, 1'b1, 3'd1, 6);
		wait_drained();

		finish_run();
	end

endmodule

// File: aes_ctrl_top.f
common/aes_ctrl_pkg.sv
hw/word_rx.sv
hw/cmd_key_loader.sv
chain_mode/chain_mode_unit.sv
hw/word_tx.sv
hw/aes_ctrl_top.sv
dv/tb_cipher_engine.sv
dv/aes_ctrl_tb.sv

// File: Makefile
# Verilator flow for the cipher controller

VERILATOR ?= verilator
TOP       ?= aes_ctrl_tb
RTL_TOP   ?= aes_ctrl_top
FILELIST  ?= aes_ctrl_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= FAIL: see errors above

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
